/* include/ddr3_phy_settings.svh */
`ifndef DDR3_PHY_SETTINGS_SVH
`define DDR3_PHY_SETTINGS_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------

// dram data pins, one beat
`define DDR3_DQ_WIDTH 16
// one mask pin per data byte
`define DDR3_DM_WIDTH (`DDR3_DQ_WIDTH / 8)
// row / column address pins
`define DDR3_ADDR_BITS 14

// --------------------------------------------------
// read timing
// --------------------------------------------------

// read latency after reset, in controller clocks
`define DDR3_TPHY_RDLAT 4
// read-valid shifter depth, largest usable latency is one less
`define DDR3_RD_SHIFT_W 12
// low bit of the latency field in the config word
`define DDR3_CFG_RDLAT_LSB 8

`endif

/* design/ddr3_phy_pkg.sv */
`default_nettype none

`include "ddr3_phy_settings.svh"

package ddr3_phy_pkg;

  // --------------------------------------------------
  // dfi command
  // --------------------------------------------------

  // one command word, same layout on dfi and pad side
  // all zero means cke and reset_n low, dram held off
  typedef struct packed {
    logic                         cke;
    logic                         reset_n;
    logic                         cs_n;
    logic                         ras_n;
    logic                         cas_n;
    logic                         we_n;
    logic                         odt;
    logic [2:0]                   bank;
    logic [`DDR3_ADDR_BITS-1:0]   address;
  } dfi_cmd_t;

  // --------------------------------------------------
  // data words
  // --------------------------------------------------

  // two dram beats per controller clock
  // beat0 goes out first on the pins
  typedef struct packed {
    logic [`DDR3_DQ_WIDTH-1:0] beat1;
    logic [`DDR3_DQ_WIDTH-1:0] beat0;
  } pad_word_t;

  // write beat pair plus byte mask, mask bit set drops the byte
  typedef struct packed {
    pad_word_t                     data;
    logic [2*`DDR3_DM_WIDTH-1:0]   mask;
  } dfi_wrdata_t;

  // --------------------------------------------------
  // configuration
  // --------------------------------------------------

  // read latency in controller clocks, 0 to shift depth - 1
  typedef struct packed {
    logic [3:0] rd_lat;
  } phy_cfg_t;

  // wishbone word address of the config register
  localparam logic [3:0] PHY_CFG_ADDR = 4'd0;

endpackage

`default_nettype wire

/* design/ddr3_phy_cfg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ddr3_phy_settings.svh"

module ddr3_phy_cfg_regs (
  input  wire                      clock,
  input  wire                      reset,

  // wishbone classic slave
  input  wire                      wb_cyc_i,
  input  wire                      wb_stb_i,
  input  wire                      wb_we_i,
  input  wire  [3:0]               wb_adr_i,
  input  wire  [31:0]              wb_dat_i,
  input  wire  [3:0]               wb_sel_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o,

  // phy configuration to the read path
  output ddr3_phy_pkg::phy_cfg_t   cfg_o
);

  import ddr3_phy_pkg::*;

  // width of the latency field in the config word
  localparam int LAT_W = 4;
  localparam int LAT_LSB = `DDR3_CFG_RDLAT_LSB;
  // byte lane that carries the latency field
  localparam int LAT_SEL = LAT_LSB / 8;
  // largest latency the shifter can hold
  localparam logic [LAT_W-1:0] RD_LAT_MAX = LAT_W'(`DDR3_RD_SHIFT_W - 1);

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------

  phy_cfg_t          cfg_q;
  logic              req_w;
  logic              hit_w;
  logic              wr_en_w;
  logic [LAT_W-1:0]  wr_lat_w;
  logic [LAT_W-1:0]  sat_lat_w;
  logic [31:0]       rd_word_w;

  // new request only while no ack is out,
  // so a held stb does not get a second ack straight away
  assign req_w = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign hit_w = (wb_adr_i == PHY_CFG_ADDR);

  // write lands only on the config word with the latency byte selected
  assign wr_en_w = req_w && wb_we_i && hit_w && wb_sel_i[LAT_SEL];

  // clamp oversized latencies to the shifter depth
  assign wr_lat_w  = wb_dat_i[LAT_LSB +: LAT_W];
  assign sat_lat_w = (wr_lat_w > RD_LAT_MAX) ? RD_LAT_MAX : wr_lat_w;

  // read word, latency field in place, zeros elsewhere
  always_comb begin
    rd_word_w = '0;
    if (hit_w) begin
      rd_word_w[LAT_LSB +: LAT_W] = cfg_q.rd_lat;
    end
  end

  // --------------------------------------------------
  // config register
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      cfg_q.rd_lat <= LAT_W'(`DDR3_TPHY_RDLAT);
    end else if (wr_en_w) begin
      cfg_q.rd_lat <= sat_lat_w;
    end
  end

  assign cfg_o = cfg_q;

  // --------------------------------------------------
  // ack and read data
  // --------------------------------------------------

  // ack one edge after the request is seen, high for one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req_w;
    end
  end

  // read data is sampled with the request and held until the next one
  always_ff @(posedge clock) begin
    if (req_w) begin
      wb_dat_o <= rd_word_w;
    end
  end

endmodule

`default_nettype wire

/* design/ddr3_phy_write_path.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ddr3_phy_settings.svh"

module ddr3_phy_write_path (
  input  wire                           clock,
  input  wire                           reset,

  // dfi write side
  input  ddr3_phy_pkg::dfi_cmd_t        dfi_cmd_i,
  input  ddr3_phy_pkg::dfi_wrdata_t     dfi_wrdata_i,
  input  wire                           dfi_wrdata_en_i,

  // pad side
  output ddr3_phy_pkg::dfi_cmd_t        ddr3_cmd_o,
  output ddr3_phy_pkg::pad_word_t       pad_dq_o,
  output logic [2*`DDR3_DM_WIDTH-1:0]   pad_dm_o,
  output logic                          pad_dq_oe_o
);

  import ddr3_phy_pkg::*;

  // --------------------------------------------------
  // command
  // --------------------------------------------------

  dfi_cmd_t cmd_q;

  // one register stage toward the pins,
  // zero in reset keeps cke and reset_n low
  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= dfi_cmd_i;
    end
  end

  assign ddr3_cmd_o = cmd_q;

  // --------------------------------------------------
  // write data and mask
  // --------------------------------------------------

  dfi_wrdata_t wr_q;

  // data and mask follow the controller every cycle,
  // the output enable decides whether the pins see them
  always_ff @(posedge clock) begin
    wr_q <= dfi_wrdata_i;
  end

  assign pad_dq_o = wr_q.data;
  assign pad_dm_o = wr_q.mask;

  // --------------------------------------------------
  // data output enable
  // --------------------------------------------------

  // three-stage delay of the write-data enable
  logic wr_en_q0;
  logic wr_en_q1;
  logic wr_en_q2;
  // active low enable, sticky across short gaps
  logic dq_oe_n_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_en_q0 <= 1'b0;
      wr_en_q1 <= 1'b0;
      wr_en_q2 <= 1'b0;
    end else begin
      wr_en_q0 <= dfi_wrdata_en_i;
      wr_en_q1 <= wr_en_q0;
      wr_en_q2 <= wr_en_q1;
    end
  end

  // second stage switches the drivers on,
  // they go off only once stages two and three are both idle
  always_ff @(posedge clock) begin
    if (reset) begin
      dq_oe_n_q <= 1'b1;
    end else if (wr_en_q1) begin
      dq_oe_n_q <= 1'b0;
    end else if (!wr_en_q2) begin
      dq_oe_n_q <= 1'b1;
    end
  end

  // pads take an active high enable
  assign pad_dq_oe_o = !dq_oe_n_q;

endmodule

`default_nettype wire

/* design/ddr3_phy_read_path.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ddr3_phy_settings.svh"

module ddr3_phy_read_path (
  input  wire                        clock,
  input  wire                        reset,

  // latency from the config register
  input  ddr3_phy_pkg::phy_cfg_t     cfg_i,

  // dfi read request
  input  wire                        dfi_rddata_en_i,

  // pad side read word
  input  ddr3_phy_pkg::pad_word_t    pad_dq_i,

  // dfi read return
  output ddr3_phy_pkg::pad_word_t    dfi_rddata_o,
  output logic                       dfi_rddata_valid_o
);

  import ddr3_phy_pkg::*;

  localparam int SHIFT_W = `DDR3_RD_SHIFT_W;

  // --------------------------------------------------
  // read data capture
  // --------------------------------------------------

  pad_word_t rd_data_q;

  // capture the pad word every cycle,
  // valid marks the cycles the controller should take
  always_ff @(posedge clock) begin
    rd_data_q <= pad_dq_i;
  end

  assign dfi_rddata_o = rd_data_q;

  // --------------------------------------------------
  // read valid shifter
  // --------------------------------------------------

  logic [SHIFT_W-1:0] rd_en_q;
  logic [SHIFT_W-1:0] rd_en_next;

  // shift right by one, then drop the new request at the latency slot
  // bit zero reaches the output, so latency n gives valid n edges later
  // config saturates the latency, the slot is always inside the vector
  always_comb begin
    rd_en_next = {1'b0, rd_en_q[SHIFT_W-1:1]};
    rd_en_next[cfg_i.rd_lat] = dfi_rddata_en_i;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_en_q <= '0;
    end else begin
      rd_en_q <= rd_en_next;
    end
  end

  assign dfi_rddata_valid_o = rd_en_q[0];

endmodule

`default_nettype wire

/* design/ddr3_dfi_phy.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ddr3_phy_settings.svh"

module ddr3_dfi_phy (
  input  wire                           clock,
  input  wire                           reset,

  // wishbone classic config port
  input  wire                           wb_cyc_i,
  input  wire                           wb_stb_i,
  input  wire                           wb_we_i,
  input  wire  [3:0]                    wb_adr_i,
  input  wire  [31:0]                   wb_dat_i,
  input  wire  [3:0]                    wb_sel_i,
  output logic [31:0]                   wb_dat_o,
  output logic                          wb_ack_o,

  // dfi from the controller
  input  ddr3_phy_pkg::dfi_cmd_t        dfi_cmd_i,
  input  ddr3_phy_pkg::dfi_wrdata_t     dfi_wrdata_i,
  input  wire                           dfi_wrdata_en_i,
  input  wire                           dfi_rddata_en_i,
  output ddr3_phy_pkg::pad_word_t       dfi_rddata_o,
  output logic                          dfi_rddata_valid_o,

  // pad side, bidirectional dq split into in, out and enable
  output ddr3_phy_pkg::dfi_cmd_t        ddr3_cmd_o,
  output ddr3_phy_pkg::pad_word_t       pad_dq_o,
  output logic [2*`DDR3_DM_WIDTH-1:0]   pad_dm_o,
  output logic                          pad_dq_oe_o,
  input  ddr3_phy_pkg::pad_word_t       pad_dq_i
);

  import ddr3_phy_pkg::*;

  // latency setting toward the read path
  phy_cfg_t cfg_w;

  // --------------------------------------------------
  // configuration
  // --------------------------------------------------

  ddr3_phy_cfg_regs u_cfg (
    .clock    (clock),
    .reset    (reset),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg_o    (cfg_w)
  );

  // --------------------------------------------------
  // command and write data
  // --------------------------------------------------

  ddr3_phy_write_path u_wr (
    .clock           (clock),
    .reset           (reset),
    .dfi_cmd_i       (dfi_cmd_i),
    .dfi_wrdata_i    (dfi_wrdata_i),
    .dfi_wrdata_en_i (dfi_wrdata_en_i),
    .ddr3_cmd_o      (ddr3_cmd_o),
    .pad_dq_o        (pad_dq_o),
    .pad_dm_o        (pad_dm_o),
    .pad_dq_oe_o     (pad_dq_oe_o)
  );

  // --------------------------------------------------
  // read capture and valid
  // --------------------------------------------------

  ddr3_phy_read_path u_rd (
    .clock              (clock),
    .reset              (reset),
    .cfg_i              (cfg_w),
    .dfi_rddata_en_i    (dfi_rddata_en_i),
    .pad_dq_i           (pad_dq_i),
    .dfi_rddata_o       (dfi_rddata_o),
    .dfi_rddata_valid_o (dfi_rddata_valid_o)
  );

endmodule

`default_nettype wire

/* tb/ddr3_phy_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ddr3_phy_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  // 4 ns period, reset held for 16 rising edges
  initial begin
    clock_o = 1'b0;
    reset_o = 1'b1;
    forever #2 clock_o = ~clock_o;
  end

  // release on a falling edge, away from the tb drive point
  initial begin
    repeat (16) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb/ddr3_dfi_phy_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module ddr3_dfi_phy_sva (
  input wire clock,
  input wire reset,
  input wire wb_cyc_i,
  input wire wb_stb_i,
  input wire wb_ack_o,
  input wire dfi_wrdata_en_i,
  input wire pad_dq_oe_o,
  input wire dfi_rddata_valid_o
);

  // failed assertions, polled by the testbench
  int err_count = 0;

  // classic ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge clock) disable iff (reset)
    wb_ack_o |=> !wb_ack_o)
    else begin
      $error("wishbone ack high two cycles in a row");
      err_count++;
    end

  // ack only answers a request seen one edge earlier
  a_ack_req: assert property (@(posedge clock) disable iff (reset)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      $error("wishbone ack without a request");
      err_count++;
    end

  // enable goes high after edge F+2, seen here one edge later
  a_oe_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(pad_dq_oe_o) |-> $past(dfi_wrdata_en_i, 3))
    else begin
      $error("dq output enable rose without write enable");
      err_count++;
    end

  // outputs still idle in the first cycle out of reset
  a_reset_idle: assert property (@(posedge clock)
    $fell(reset) |-> (!dfi_rddata_valid_o && !pad_dq_oe_o))
    else begin
      $error("valid or output enable high after reset");
      err_count++;
    end

endmodule

bind ddr3_dfi_phy ddr3_dfi_phy_sva u_sva (.*);

`default_nettype wire

/* tb/ddr3_dfi_phy_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ddr3_phy_settings.svh"

module ddr3_dfi_phy_tb;

  import ddr3_phy_pkg::*;

  logic                          clock;
  logic                          reset;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [3:0]                    wb_adr;
  logic [31:0]                   wb_dat;
  logic [3:0]                    wb_sel;
  logic [31:0]                   wb_dat_o;
  logic                          wb_ack_o;
  dfi_cmd_t                      dfi_cmd;
  dfi_wrdata_t                   dfi_wrdata;
  logic                          dfi_wrdata_en;
  logic                          dfi_rddata_en;
  pad_word_t                     dfi_rddata_o;
  logic                          dfi_rddata_valid_o;
  dfi_cmd_t                      ddr3_cmd_o;
  pad_word_t                     pad_dq_o;
  logic [2*`DDR3_DM_WIDTH-1:0]   pad_dm_o;
  logic                          pad_dq_oe_o;
  pad_word_t                     pad_dq;

  // run limit, set once the cases are read
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [31:0] rng_q = 32'd89698;
  string       lines[$];

  ddr3_phy_clock_gen u_clk (
    .clock_o (clock),
    .reset_o (reset)
  );

  ddr3_dfi_phy u_dut (
    .clock              (clock),
    .reset              (reset),
    .wb_cyc_i           (wb_cyc),
    .wb_stb_i           (wb_stb),
    .wb_we_i            (wb_we),
    .wb_adr_i           (wb_adr),
    .wb_dat_i           (wb_dat),
    .wb_sel_i           (wb_sel),
    .wb_dat_o           (wb_dat_o),
    .wb_ack_o           (wb_ack_o),
    .dfi_cmd_i          (dfi_cmd),
    .dfi_wrdata_i       (dfi_wrdata),
    .dfi_wrdata_en_i    (dfi_wrdata_en),
    .dfi_rddata_en_i    (dfi_rddata_en),
    .dfi_rddata_o       (dfi_rddata_o),
    .dfi_rddata_valid_o (dfi_rddata_valid_o),
    .ddr3_cmd_o         (ddr3_cmd_o),
    .pad_dq_o           (pad_dq_o),
    .pad_dm_o           (pad_dm_o),
    .pad_dq_oe_o        (pad_dq_oe_o),
    .pad_dq_i           (pad_dq)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // idle filler for data buses
  task automatic next_filler(output logic [31:0] val);
    rng_q = xorshift32(rng_q);
    val = rng_q;
  endtask

  // inputs change 1 ns after the edge, outputs are settled by then
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout, cases not finished after %0d cycles", cycle_count);
      stop_on_failure();
    end
    if (u_dut.u_sva.err_count != 0) begin
      $display("a bound assertion failed on an earlier edge");
      stop_on_failure();
    end
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic check_cmd(input string tname, input dfi_cmd_t exp, input dfi_cmd_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", tname, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_word(input string tname, input pad_word_t exp, input pad_word_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", tname, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input string tname, input logic [2*`DDR3_DM_WIDTH-1:0] exp,
                            input logic [2*`DDR3_DM_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", tname, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_reg(input string tname, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", tname, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string tname, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s expected %b actual %b", tname, exp, act);
      stop_on_failure();
    end
  endtask

  // --------------------------------------------------
  // wishbone classic master
  // --------------------------------------------------

  // ack one edge after the request, gone the edge after with stb held
  task automatic wb_xfer(input string tname, input logic we, input logic [3:0] adr,
                         input logic [31:0] dat, input logic [3:0] sel,
                         output logic [31:0] rdat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    wb_sel = sel;
    next_cycle();
    check_bit({tname, " ack"}, 1'b1, wb_ack_o);
    rdat = wb_dat_o;
    next_cycle();
    check_bit({tname, " ack drop"}, 1'b0, wb_ack_o);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // --------------------------------------------------
  // case runners
  // --------------------------------------------------

  task automatic run_burst(input string tname, input logic [31:0] bd[3], input logic [3:0] bm[3]);
    logic [31:0] fill;
    for (int j = 0; j < 8; j++) begin
      if (j < 3) begin
        dfi_wrdata.data = pad_word_t'(bd[j]);
        dfi_wrdata.mask = bm[j];
        dfi_wrdata_en   = 1'b1;
      end else begin
        next_filler(fill);
        dfi_wrdata.data = pad_word_t'(fill);
        dfi_wrdata.mask = fill[3:0];
        dfi_wrdata_en   = 1'b0;
      end
      next_cycle();
      if (j < 3) begin
        check_word({tname, " dq"}, pad_word_t'(bd[j]), pad_dq_o);
        check_mask({tname, " dm"}, bm[j], pad_dm_o);
      end
      // on two edges after the first word, off four after the last
      check_bit({tname, " oe"}, (j >= 2 && j <= 5), pad_dq_oe_o);
    end
  endtask

  task automatic run_reads(input string tname, input logic [3:0] lat, input logic [3:0] en_pat,
                           input logic [31:0] rw[4]);
    logic [31:0] fill;
    logic [31:0] rd;
    logic        exp_v;
    int          idx;
    wb_xfer({tname, " lat write"}, 1'b1, PHY_CFG_ADDR, {20'd0, lat, 8'd0}, 4'hf, rd);
    for (int c = 0; c < 4 + lat + 2; c++) begin
      dfi_rddata_en = (c < 4) ? en_pat[c] : 1'b0;
      next_filler(fill);
      exp_v = 1'b0;
      idx   = 0;
      // pad model, word sampled at the edge its valid bit lands
      for (int k = 0; k < 4; k++) begin
        if (en_pat[k] && (k + lat == c)) begin
          exp_v = 1'b1;
          idx   = k;
        end
      end
      pad_dq = exp_v ? pad_word_t'(rw[idx]) : pad_word_t'(fill);
      next_cycle();
      check_bit({tname, " valid"}, exp_v, dfi_rddata_valid_o);
      if (exp_v) begin
        check_word({tname, " rddata"}, pad_word_t'(rw[idx]), dfi_rddata_o);
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int          fd;
    string       line;
    string       kind;
    string       tname;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] rd;
    logic [31:0] bd[3];
    logic [3:0]  bm[3];
    logic [31:0] rw[4];
    int          n;
    dfi_cmd_t    rst_cmd;
    logic        rst_oe;
    logic        rst_valid;

    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat        = '0;
    wb_sel        = '0;
    // controller busy while reset is held
    // only the reset can keep the pad side idle
    dfi_cmd       = '1;
    dfi_wrdata    = '0;
    dfi_wrdata_en = 1'b1;
    dfi_rddata_en = 1'b1;
    pad_dq        = '0;

    fd = $fopen("tb/ddr3_phy_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/ddr3_phy_cases.txt");
      stop_on_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 2 && line.substr(0, 0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    cycle_limit = 64 + 40 * lines.size();

    // edge 16 is the last one inside reset
    // outputs seen there are the reset state
    repeat (16) next_cycle();
    rst_cmd       = ddr3_cmd_o;
    rst_oe        = pad_dq_oe_o;
    rst_valid     = dfi_rddata_valid_o;
    dfi_cmd       = '0;
    dfi_wrdata_en = 1'b0;
    dfi_rddata_en = 1'b0;

    wait (!reset);
    next_cycle();

    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%s %s", kind, tname);
      if (kind == "R") begin
        n = $sscanf(lines[i], "%s %s %h", kind, tname, f0);
        check_cmd({tname, " cmd"}, '0, rst_cmd);
        check_bit({tname, " oe"}, 1'b0, rst_oe);
        check_bit({tname, " valid"}, 1'b0, rst_valid);
        wb_xfer(tname, 1'b0, PHY_CFG_ADDR, '0, 4'hf, rd);
        check_reg(tname, f0, rd);
      end else if (kind == "W") begin
        n = $sscanf(lines[i], "%s %s %h %h %h", kind, tname, f0, f1, f2);
        wb_xfer({tname, " write"}, 1'b1, PHY_CFG_ADDR, f0, f1[3:0], rd);
        wb_xfer({tname, " read"}, 1'b0, PHY_CFG_ADDR, '0, 4'hf, rd);
        check_reg(tname, f2, rd);
      end else if (kind == "G") begin
        n = $sscanf(lines[i], "%s %s %h %h", kind, tname, f0, f1);
        wb_xfer(tname, 1'b0, f0[3:0], '0, 4'hf, rd);
        check_reg(tname, f1, rd);
      end else if (kind == "C") begin
        n = $sscanf(lines[i], "%s %s %h", kind, tname, f0);
        dfi_cmd = dfi_cmd_t'(f0[23:0]);
        next_cycle();
        check_cmd(tname, dfi_cmd_t'(f0[23:0]), ddr3_cmd_o);
      end else if (kind == "B") begin
        n = $sscanf(lines[i], "%s %s %h %h %h %h %h %h", kind, tname,
                    bd[0], bm[0], bd[1], bm[1], bd[2], bm[2]);
        run_burst(tname, bd, bm);
      end else if (kind == "L") begin
        n = $sscanf(lines[i], "%s %s %h %h %h %h %h %h", kind, tname,
                    f0, f1, rw[0], rw[1], rw[2], rw[3]);
        run_reads(tname, f0[3:0], f1[3:0], rw);
      end else begin
        $display("unknown case kind %s in the cases file", kind);
        stop_on_failure();
      end
    end

    next_cycle();
    if (u_dut.u_sva.err_count != 0) begin
      $display("%0d assertion failures during the run", u_dut.u_sva.err_count);
      stop_on_failure();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
design/ddr3_phy_pkg.sv
design/ddr3_phy_cfg_regs.sv
design/ddr3_phy_write_path.sv
design/ddr3_phy_read_path.sv
design/ddr3_dfi_phy.sv
tb/ddr3_phy_clock_gen.sv
tb/ddr3_dfi_phy_sva.sv
tb/ddr3_dfi_phy_tb.sv

/* tb/ddr3_phy_cases.txt */
# kind name fields, all hex; one test per line
# R name rd_word | W name wr_data sel rd_word | G name adr rd_word | C name cmd
# B name d0 m0 d1 m1 d2 m2 | L name rd_lat enables(bit k = cycle k) w0 w1 w2 w3
R reset_state 00000400
W lat_7 00000700 f 00000700
W lat_11 00000b00 2 00000b00
W lat_sat_15 00000f00 f 00000b00
W lat_sat_12 a5a5ac5a 2 00000b00
W sel_clear 00000300 d 00000b00
W lat_2 00000200 2 00000200
G other_adr_3 3 00000000
G other_adr_f f 00000000
C cmd_reset_low 000000
C cmd_cke_up c00000
C cmd_activate dc9abc
C cmd_write f93fff
C cmd_read e52001
C cmd_refresh e74000
B burst_a 01234567 0 89abcdef 5 deadbeef a
B burst_b ffff0000 f 0000ffff 0 5a5aa5a5 3
L rd_lat_0 0 b 11111111 22222222 33333333 44444444
L rd_lat_1 1 f a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3
L rd_lat_4 4 5 cafe0001 cafe0002 cafe0003 cafe0004
L rd_lat_11 b 9 0badf00d 12345678 87654321 feedface
L rd_lat_7 7 3 76543210 fedcba98 00000000 00000000
